/* all.f */
bus_pkg.sv
cmd_decode.sv
cmd_execute.sv
cmd_result.sv
bus_arbiter.sv
scratch_ram.sv
audio_fetch.sv
bus_system.sv
bus_system_assert.sv
tb_bus_system.sv

/* Makefile */
TOP := tb_bus_system

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* tb_bus_system.sv */
`default_nettype none

module tb_bus_system import bus_pkg::*; ();

  localparam int NUM_WR          = 40;
  localparam int AUDIO_SAMPLES   = 24;   // three trips round the ring
  localparam int RSP_LIMIT       = 200;  // cycles allowed for one response
  localparam int CMD_EST         = 300;
  localparam int CMD_CYCLES      = 20;
  localparam int WATCHDOG_CYCLES = 2 * (CMD_EST * CMD_CYCLES + AUDIO_SAMPLES * SAMPLE_TICKS);

  logic          clk50MHz;
  logic          arst_n;
  logic          cmd_valid;
  cmd_word_t     cmd;
  logic          audio_en;
  logic          cmd_busy;
  logic          rsp_valid;
  rsp_t          rsp;
  audio_sample_t audio_out;

  logic [DATA_W-1:0] ram_model [RAM_DEPTH];
  logic [ADDR_W-1:0] used_addr [$];  // addresses whose model value is known
  audio_sample_t     ring [AUDIO_LEN];
  int                errors;
  int                checks;
  logic              audio_watch;
  audio_sample_t     last_sample;
  int                ring_pos;
  int                sample_count;

  bus_system dut (
    .clk50MHz  (clk50MHz),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .audio_en  (audio_en),
    .cmd_busy  (cmd_busy),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .audio_out (audio_out)
  );

  always #10 clk50MHz = ~clk50MHz;

  task automatic check_rsp(input string name, input rsp_t exp, input rsp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      // fields shown as op/addr/data/error
      $display("[ERROR] %0t %s: expected %0d/%h/%h/%b, got %0d/%h/%h/%b", $time, name,
               exp.op, exp.addr, exp.data, exp.error, act.op, act.addr, act.data, act.error);
    end
  endtask

  task automatic check_sample(input string name, input audio_sample_t exp,
                              input audio_sample_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %-8s passed", name);
    end else begin
      $display("test %-8s failed with %0d errors", name, errors - errs_before);
    end
  endtask

  function automatic cmd_word_t make_cmd(input logic [OP_W-1:0] op,
                                         input logic [ADDR_W-1:0] addr,
                                         input logic [DATA_W-1:0] data);
    cmd_word_t c;
    c.op   = op;
    c.addr = addr;
    c.data = data;
    return c;
  endfunction

  function automatic logic [DATA_W-1:0] rand_data();
    return DATA_W'($urandom);
  endfunction

  function automatic logic [ADDR_W-1:0] rand_addr();
    return ADDR_W'($urandom % AUDIO_BASE);   // keeps clear of the sample ring
  endfunction

  function automatic logic [ADDR_W-1:0] pick_addr();
    return used_addr[$urandom % used_addr.size()];
  endfunction

  // expected response, memory model follows the command
  function automatic rsp_t model_rsp(input cmd_word_t c);
    rsp_t r;
    r.op    = CMD_NOP;
    r.addr  = c.addr;
    r.data  = '0;
    r.error = 1'b0;
    case (c.op)
      CMD_NOP: r.op = CMD_NOP;
      CMD_WRITE: begin
        r.op = CMD_WRITE;
        r.data = c.data;
        ram_model[c.addr] = c.data;
      end
      CMD_READ: begin
        r.op = CMD_READ;
        r.data = ram_model[c.addr];
      end
      CMD_ADD: begin
        r.op = CMD_ADD;
        r.data = ram_model[c.addr] + c.data;   // 16-bit wrap
        ram_model[c.addr] = r.data;
      end
      default: r.error = 1'b1;
    endcase
    return r;
  endfunction

  task automatic send_cmd(input cmd_word_t c);
    rsp_t exp;
    int   wait_cycles;
    exp = model_rsp(c);
    @(negedge clk50MHz);
    cmd_valid = 1'b1;
    cmd       = c;
    @(negedge clk50MHz);
    cmd_valid = 1'b0;
    wait_cycles = 0;
    while (!rsp_valid && wait_cycles < RSP_LIMIT) begin
      @(negedge clk50MHz);
      wait_cycles++;
    end
    if (!rsp_valid) begin
      errors++;
      $display("no response to command op %0d at addr %h within %0d cycles",
               c.op, c.addr, RSP_LIMIT);
    end else begin
      check_rsp("rsp", exp, rsp);
    end
  endtask

  task automatic random_cmd();
    logic [ADDR_W-1:0] a;
    case ($urandom % 3)
      0: begin
        a = rand_addr();
        send_cmd(make_cmd(CMD_WRITE, a, rand_data()));
        used_addr.push_back(a);
      end
      1: send_cmd(make_cmd(CMD_READ, pick_addr(), '0));
      default: send_cmd(make_cmd(CMD_ADD, pick_addr(), rand_data()));
    endcase
  endtask

  task automatic test_reset();
    int errs_before;
    errs_before = errors;
    check_bit("cmd_busy", 1'b0, cmd_busy);
    check_bit("rsp_valid", 1'b0, rsp_valid);
    check_sample("audio_out", '0, audio_out);
    end_test("reset", errs_before);
  endtask

  task automatic test_write_read();
    int                errs_before;
    logic [ADDR_W-1:0] a;
    errs_before = errors;
    repeat (NUM_WR) begin
      a = rand_addr();
      send_cmd(make_cmd(CMD_WRITE, a, rand_data()));
      used_addr.push_back(a);
    end
    foreach (used_addr[i]) begin
      send_cmd(make_cmd(CMD_READ, used_addr[i], '0));
    end
    end_test("wr_rd", errs_before);
  endtask

  task automatic test_add();
    int                errs_before;
    logic [ADDR_W-1:0] a;
    errs_before = errors;
    repeat (4) begin
      a = pick_addr();
      send_cmd(make_cmd(CMD_ADD, a, rand_data()));
      send_cmd(make_cmd(CMD_READ, a, '0));
    end
    a = 8'h20;
    send_cmd(make_cmd(CMD_WRITE, a, 16'hfff0));
    used_addr.push_back(a);
    send_cmd(make_cmd(CMD_ADD, a, 16'h0025));   // wraps to 0015
    send_cmd(make_cmd(CMD_READ, a, '0));
    end_test("add", errs_before);
  endtask

  task automatic test_illegal();
    int                errs_before;
    logic [ADDR_W-1:0] a;
    errs_before = errors;
    for (int code = 4; code < 16; code++) begin
      a = pick_addr();
      send_cmd(make_cmd(OP_W'(code), a, rand_data()));
      send_cmd(make_cmd(CMD_READ, a, '0));
    end
    end_test("illegal", errs_before);
  endtask

  task automatic test_ignored();
    int                errs_before;
    int                pulses;
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    rsp_t              exp;
    errs_before = errors;
    pulses = 0;
    a = pick_addr();
    d = rand_data();
    exp = model_rsp(make_cmd(CMD_WRITE, a, d));
    @(negedge clk50MHz);
    cmd_valid = 1'b1;
    cmd       = make_cmd(CMD_WRITE, a, d);
    @(negedge clk50MHz);
    cmd_valid = 1'b0;
    @(negedge clk50MHz);
    if (!cmd_busy) begin
      errors++;
      $display("cmd_busy was low when the second strobe went out");
    end
    cmd_valid = 1'b1;
    cmd       = make_cmd(CMD_WRITE, a, ~d);
    @(negedge clk50MHz);
    cmd_valid = 1'b0;
    repeat (40) begin
      @(negedge clk50MHz);
      if (rsp_valid) begin
        pulses++;
        check_rsp("rsp", exp, rsp);
      end
    end
    if (pulses != 1) begin
      errors++;
      $display("expected one response after the doubled strobe, saw %0d", pulses);
    end
    send_cmd(make_cmd(CMD_READ, a, '0));
    end_test("ignored", errs_before);
  endtask

  task automatic test_audio();
    int errs_before;
    errs_before = errors;
    for (int i = 0; i < AUDIO_LEN; i++) begin
      ring[i] = audio_sample_t'(8'h3c + 29 * i);   // distinct, none zero
      send_cmd(make_cmd(CMD_WRITE, AUDIO_BASE + ADDR_W'(i), {8'($urandom), ring[i]}));
    end
    @(negedge clk50MHz);
    audio_watch = 1'b1;
    audio_en    = 1'b1;
    while (sample_count < AUDIO_SAMPLES) begin
      random_cmd();
    end
    audio_watch = 1'b0;
    @(negedge clk50MHz);
    audio_en = 1'b0;
    end_test("audio", errs_before);
  endtask

  // every change of the level must be the next sample of the ring
  always @(negedge clk50MHz) begin
    if (!audio_watch) begin
      ring_pos     = 0;
      sample_count = 0;
    end else if (audio_out !== last_sample) begin
      check_sample("audio_out", ring[ring_pos], audio_out);
      ring_pos = (ring_pos + 1) % AUDIO_LEN;
      sample_count++;
    end
    last_sample = audio_out;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk50MHz);
    $display("timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    clk50MHz    = 1'b0;
    arst_n      = 1'b0;
    cmd_valid   = 1'b0;
    cmd         = '0;
    audio_en    = 1'b0;
    audio_watch = 1'b0;
    errors      = 0;
    checks      = 0;
    void'($urandom(32'hd94d432b));
    repeat (16) @(posedge clk50MHz);
    @(negedge clk50MHz);
    arst_n = 1'b1;
    @(negedge clk50MHz);
    test_reset();
    test_write_read();
    test_add();
    test_illegal();
    test_ignored();
    test_audio();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bus_system_assert.sv */
`default_nettype none

module bus_system_assert import bus_pkg::*; (
  input wire logic                   clk50MHz,
  input wire logic                   arst_n,
  input wire logic [NUM_MASTERS-1:0] req,
  input wire logic [NUM_MASTERS-1:0] ack
);

  // never two masters on the bus at once
  ack_onehot: assert property (@(posedge clk50MHz) disable iff (!arst_n)
    $onehot0(ack))
    else $error("ack is not one-hot or zero: %b", ack);

  // a fresh grant only goes to a master that is asking for the bus
  ack_to_requester: assert property (@(posedge clk50MHz) disable iff (!arst_n)
    (ack & ~$past(ack) & ~req) == '0)
    else $error("ack %b given to a master without req %b", ack, req);

  held_grant: assert property (@(posedge clk50MHz) disable iff (!arst_n)
    |(ack & req) |=> ack == $past(ack))
    else $error("grant moved while its holder still requested the bus");

endmodule

bind bus_arbiter bus_system_assert u_arb_assert (
  .clk50MHz (clk50MHz),
  .arst_n   (arst_n),
  .req      (req),
  .ack      (ack)
);

`default_nettype wire

/* bus_system.sv */
`default_nettype none

module bus_system import bus_pkg::*; (
  input  wire logic      clk50MHz,
  input  wire logic      arst_n,
  input  wire logic      cmd_valid,
  input  wire cmd_word_t cmd,
  input  wire logic      audio_en,
  output logic           cmd_busy,
  output logic           rsp_valid,
  output rsp_t           rsp,
  output audio_sample_t  audio_out
);

  logic                   dec_valid;
  decoded_cmd_t           dec;
  logic                   exec_done;
  logic [DATA_W-1:0]      result_data;
  wire  [NUM_MASTERS-1:0] req;        // one bit per master
  logic [NUM_MASTERS-1:0] ack;
  bus_ctrl_t              master_ctrl [NUM_MASTERS];
  bus_ctrl_t              bus_ctrl;
  bus_resp_t              bus_resp;   // broadcast to both masters

  cmd_decode u_decode (
    .clk50MHz  (clk50MHz),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (cmd_busy),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  cmd_execute u_execute (
    .clk50MHz    (clk50MHz),
    .arst_n      (arst_n),
    .dec_valid   (dec_valid),
    .dec         (dec),
    .ack         (ack[CMD_ID]),
    .bus_resp    (bus_resp),
    .req         (req[CMD_ID]),
    .bus_out     (master_ctrl[CMD_ID]),
    .done        (exec_done),
    .result_data (result_data)
  );

  cmd_result u_result (
    .clk50MHz    (clk50MHz),
    .arst_n      (arst_n),
    .dec_valid   (dec_valid),
    .dec         (dec),
    .done        (exec_done),
    .result_data (result_data),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp),
    .busy        (cmd_busy)
  );

  bus_arbiter u_arbiter (
    .clk50MHz_unused_guard ('0),
    .clk50MHz (clk50MHz),
    .arst_n   (arst_n),
    .req      (req),
    .ctrl_in  (master_ctrl),
    .ack      (ack),
    .bus_ctrl (bus_ctrl)
  );

  scratch_ram u_ram (
    .clk50MHz (clk50MHz),
    .arst_n   (arst_n),
    .bus_ctrl (bus_ctrl),
    .bus_resp (bus_resp)
  );

  audio_fetch u_audio (
    .clk50MHz  (clk50MHz),
    .arst_n    (arst_n),
    .audio_en  (audio_en),
    .ack       (ack[AUDIO_ID]),
    .bus_resp  (bus_resp),
    .req       (req[AUDIO_ID]),
    .bus_out   (master_ctrl[AUDIO_ID]),
    .audio_out (audio_out)
  );

endmodule

`default_nettype wire

/* audio_fetch.sv */
`default_nettype none

module audio_fetch import bus_pkg::*; (
  input  wire logic      clk50MHz,
  input  wire logic      arst_n,
  input  wire logic      audio_en,
  input  wire logic      ack,
  input  wire bus_resp_t bus_resp,
  output logic           req,
  output bus_ctrl_t      bus_out,
  output audio_sample_t  audio_out
);

  logic [TICK_W-1:0] tick_cnt;
  logic [IDX_W-1:0]  idx;        // position in the sample ring
  logic              req_q;
  logic              rd_pend;    // read phase issued, word not back yet
  logic              tick;
  logic              phase;
  logic              rd_hit;

  assign tick   = audio_en && (tick_cnt == TICK_W'(SAMPLE_TICKS - 1));
  assign phase  = req_q && ack;  // req drops right after, so this is the first ack cycle
  assign rd_hit = rd_pend && ack && bus_resp.valid;
  assign req    = req_q;

  always_comb begin
    bus_out = '{op: BUS_IDLE, addr: '0, wdata: '0};
    if (phase) begin
      bus_out.op   = BUS_READ;
      bus_out.addr = AUDIO_BASE + ADDR_W'(idx);
    end
  end

  always_ff @(posedge clk50MHz or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt  <= '0;
      idx       <= '0;
      req_q     <= 1'b0;
      rd_pend   <= 1'b0;
      audio_out <= '0;
    end else begin
      if (!audio_en) begin
        tick_cnt <= '0;
        idx      <= '0;
      end else begin
        tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
        if (rd_hit) begin
          idx <= (idx == IDX_W'(AUDIO_LEN - 1)) ? '0 : idx + 1'b1;
        end
      end

      // a fetch still in flight makes this tick a skip
      if (phase) begin
        req_q   <= 1'b0;
        rd_pend <= 1'b1;
      end else if (tick && !req_q && !rd_pend) begin
        req_q <= 1'b1;
      end

      if (rd_hit) begin
        rd_pend <= 1'b0;
        if (audio_en) begin
          audio_out <= bus_resp.rdata[7:0];   // low byte drives the level
        end
      end
    end
  end

endmodule

`default_nettype wire

/* scratch_ram.sv */
`default_nettype none

module scratch_ram import bus_pkg::*; (
  input  wire logic      clk50MHz,
  input  wire logic      arst_n,
  input  wire bus_ctrl_t bus_ctrl,
  output bus_resp_t      bus_resp
);

  logic [DATA_W-1:0] mem [RAM_DEPTH];
  logic [DATA_W-1:0] rdata_q;
  logic              valid_q;

  // every address decodes here, there is no other slave
  always_ff @(posedge clk50MHz) begin
    if (bus_ctrl.op == BUS_WRITE) begin
      mem[bus_ctrl.addr] <= bus_ctrl.wdata;
    end
    if (bus_ctrl.op == BUS_READ) begin
      rdata_q <= mem[bus_ctrl.addr];   // held until the next read
    end
  end

  always_ff @(posedge clk50MHz or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= (bus_ctrl.op == BUS_READ);
    end
  end

  assign bus_resp = '{valid: valid_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* bus_arbiter.sv */
`default_nettype none

module bus_arbiter import bus_pkg::*; (
  input  wire logic [NUM_MASTERS-1:0] clk50MHz_unused_guard,
  input  wire logic                   clk50MHz,
  input  wire logic                   arst_n,
  input  wire logic [NUM_MASTERS-1:0] req,
  input  wire bus_ctrl_t              ctrl_in [NUM_MASTERS],
  output logic [NUM_MASTERS-1:0]      ack,
  output bus_ctrl_t                   bus_ctrl
);

  logic [NUM_MASTERS-1:0] grant_nxt;
  logic                   hold;

  // holder keeps the bus as long as its req stays up
  assign hold = |(ack & req & ~clk50MHz_unused_guard);

  // lowest requesting index wins
  always_comb begin
    grant_nxt = '0;
    for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
      if (req[i]) begin
        grant_nxt = NUM_MASTERS'(1) << i;
      end
    end
  end

  always_ff @(posedge clk50MHz or negedge arst_n) begin
    if (!arst_n) begin
      ack <= '0;
    end else if (!hold) begin
      ack <= grant_nxt;   // re-arbitrate once the holder lets go
    end
  end

  always_comb begin
    bus_ctrl = '{op: BUS_IDLE, addr: '0, wdata: '0};
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (ack[i]) begin
        bus_ctrl = ctrl_in[i];
      end
    end
  end

endmodule

`default_nettype wire

/* cmd_result.sv */
`default_nettype none

module cmd_result import bus_pkg::*; (
  input  wire logic              clk50MHz,
  input  wire logic              arst_n,
  input  wire logic              dec_valid,
  input  wire decoded_cmd_t      dec,
  input  wire logic              done,
  input  wire logic [DATA_W-1:0] result_data,
  output logic                   rsp_valid,
  output rsp_t                   rsp,
  output logic                   busy
);

  logic busy_q;

  always_ff @(posedge clk50MHz or negedge arst_n) begin
    if (!arst_n) begin
      busy_q    <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= done;
      if (dec_valid) begin
        busy_q <= 1'b1;
      end else if (done) begin
        busy_q <= 1'b0;   // drops together with the rsp_valid pulse
      end
    end
  end

  // busy already high in the dec_valid cycle
  assign busy = busy_q | dec_valid;

  always_ff @(posedge clk50MHz) begin
    if (done) begin
      rsp.op    <= dec.op;
      rsp.addr  <= dec.addr;
      rsp.error <= dec.illegal;
      if (dec.illegal) begin
        rsp.data <= '0;
      end else if (dec.op == CMD_WRITE) begin
        rsp.data <= dec.operand;   // echo of the written word
      end else begin
        rsp.data <= result_data;
      end
    end
  end

endmodule

`default_nettype wire

/* cmd_execute.sv */
`default_nettype none

module cmd_execute import bus_pkg::*; (
  input  wire logic         clk50MHz,
  input  wire logic         arst_n,
  input  wire logic         dec_valid,
  input  wire decoded_cmd_t dec,
  input  wire logic         ack,
  input  wire bus_resp_t    bus_resp,
  output logic              req,
  output bus_ctrl_t         bus_out,
  output logic              done,
  output logic [DATA_W-1:0] result_data
);

  exec_state_t       state;
  exec_state_t       state_nxt;
  logic              wb;         // set for the write-back grant of an add
  logic              rd_hit;
  logic [DATA_W-1:0] result_q;

  assign rd_hit = (state == WAIT_RD) && ack && bus_resp.valid;

  // ack is registered, so it cannot show up in REQ; ADDR waits for it
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (dec_valid) begin
          state_nxt = (dec.illegal || dec.op == CMD_NOP) ? DONE : REQ;
        end
      end
      REQ:        state_nxt = ADDR;
      ADDR: begin
        if (ack) begin
          state_nxt = (wb || dec.op == CMD_WRITE) ? DONE : WAIT_RD;
        end
      end
      WAIT_RD: begin
        if (rd_hit) begin
          state_nxt = (dec.op == CMD_ADD) ? WRITE_BACK : DONE;
        end
      end
      WRITE_BACK: state_nxt = ADDR;   // second request of an add
      DONE:       state_nxt = IDLE;
      default:    state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk50MHz or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      wb    <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state_nxt == WRITE_BACK) begin
        wb <= 1'b1;
      end else if (state_nxt == IDLE) begin
        wb <= 1'b0;
      end
    end
  end

  // read word, or the sum for an add (wraps at 2^16)
  always_ff @(posedge clk50MHz) begin
    if (state == IDLE && dec_valid) begin
      result_q <= '0;
    end else if (rd_hit) begin
      result_q <= (dec.op == CMD_ADD) ? bus_resp.rdata + dec.operand : bus_resp.rdata;
    end
  end

  assign req = (state == REQ) || (state == ADDR) || (state == WRITE_BACK);

  // address phase only in the first cycle of ack
  always_comb begin
    bus_out = '{op: BUS_IDLE, addr: '0, wdata: '0};
    if (state == ADDR && ack) begin
      bus_out.addr = dec.addr;
      if (wb) begin
        bus_out.op    = BUS_WRITE;
        bus_out.wdata = result_q;
      end else if (dec.op == CMD_WRITE) begin
        bus_out.op    = BUS_WRITE;
        bus_out.wdata = dec.operand;
      end else begin
        bus_out.op = BUS_READ;
      end
    end
  end

  assign done        = (state == DONE);
  assign result_data = result_q;

endmodule

`default_nettype wire

/* cmd_decode.sv */
`default_nettype none

module cmd_decode import bus_pkg::*; (
  input  wire logic   clk50MHz,
  input  wire logic   arst_n,
  input  wire logic   cmd_valid,
  input  wire cmd_word_t cmd,
  input  wire logic   busy,
  output logic        dec_valid,
  output decoded_cmd_t dec
);

  logic accept;

  // strobes seen while a command is in flight are dropped
  assign accept = cmd_valid && !busy;

  always_ff @(posedge clk50MHz or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept;   // one cycle only
    end
  end

  // command fields, held until the next accepted strobe
  always_ff @(posedge clk50MHz) begin
    if (accept) begin
      dec.addr    <= cmd.addr;
      dec.operand <= cmd.data;
      case (cmd.op)
        CMD_NOP,
        CMD_WRITE,
        CMD_READ,
        CMD_ADD: begin
          dec.op      <= cmd_op_t'(cmd.op);
          dec.illegal <= 1'b0;
        end
        default: begin
          // unknown code runs like a nop but is flagged
          dec.op      <= CMD_NOP;
          dec.illegal <= 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* bus_pkg.sv */
`default_nettype none

package bus_pkg;

  localparam int DATA_W       = 16;
  localparam int ADDR_W       = 8;
  localparam int OP_W         = 4;    // opcode field of a host command
  localparam int NUM_MASTERS  = 2;
  localparam int AUDIO_ID     = 0;    // lowest index, so it wins a free bus
  localparam int CMD_ID       = 1;
  localparam logic [ADDR_W-1:0] AUDIO_BASE = 8'hF0;
  localparam int AUDIO_LEN    = 8;
  localparam int SAMPLE_TICKS = 32;
  localparam int RAM_DEPTH    = 2 ** ADDR_W;
  localparam int IDX_W        = $clog2(AUDIO_LEN);
  localparam int TICK_W       = $clog2(SAMPLE_TICKS);

  // codes 4..15 are illegal
  typedef enum logic [OP_W-1:0] {
    CMD_NOP   = 4'd0,
    CMD_WRITE = 4'd1,
    CMD_READ  = 4'd2,
    CMD_ADD   = 4'd3
  } cmd_op_t;

  typedef enum logic [1:0] {
    BUS_IDLE  = 2'd0,
    BUS_READ  = 2'd1,
    BUS_WRITE = 2'd2
  } bus_op_t;

  typedef enum logic [2:0] {
    IDLE,
    REQ,
    ADDR,
    WAIT_RD,
    WRITE_BACK,
    DONE
  } exec_state_t;

  typedef logic [7:0] audio_sample_t;

  typedef struct packed {
    logic [OP_W-1:0]   op;     // raw code as sent by the host
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } cmd_word_t;

  typedef struct packed {
    cmd_op_t           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] operand;
    logic              illegal;
  } decoded_cmd_t;

  typedef struct packed {
    bus_op_t           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_ctrl_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } bus_resp_t;

  typedef struct packed {
    cmd_op_t           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              error;
  } rsp_t;

endpackage

`default_nettype wire
